/* bench/lsu_tb.sv */
`timescale 1ns/100ps
`default_nettype none

module lsu_tb;
    import lsu_isa_pkg::*;
    import lsu_bus_pkg::*;

    localparam int MAX_OPS   = 160;
    localparam int CYC_LIMIT = 200 * MAX_OPS;   // 200 cycles per instruction

    logic clk, rst_n, priv_m, inst_valid, rd_en, mem_req_ready, mem_rsp_valid;
    logic cfg_we, cfg_r, cfg_w, inst_ready, mem_req_valid, reg_wr_en, exc_valid;
    logic [1:0] cfg_idx;
    logic [4:0] rd_idx, reg_idx;
    logic [31:0] inst, pc, rs1_val, rs2_val, imm, mem_rsp_data, cfg_base, cfg_limit;
    logic [31:0] mem_req_addr, mem_req_wdata, reg_val, exc_pc, exc_inst;
    logic [3:0] mem_req_strb;
    mem_op_e mem_req_op;
    exc_cause_e exc_cause;

    logic [31:0] mem [256];
    logic [31:0] shadow [256];
    logic [31:0] rsp_word, held_addr, held_wdata, exp_val, exp_pc, exp_inst;
    logic [3:0] held_strb;
    mem_op_e held_op;
    exc_cause_e exp_cause;
    logic stalled, resv_v;
    logic [29:0] resv_a;
    int rsp_cnt, stall_pct, max_delay, exp_kind, seen, errors, checks, cycles, issued;
    int t_err, t_chk;

    lsu_top #(.num_regions(4)) lsu_top_i (.*);

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    always @(posedge clk) begin
        cycles++;
        if (cycles > CYC_LIMIT) begin
            $display("timeout: no completion after %0d cycles", cycles);
            $display("Simulation finished: FAIL");
            $finish;
        end
    end

    task automatic check_reg(input string name, input logic [XLEN-1:0] got, exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("[ERROR] %s got %08h expected %08h", name, got, exp);
        end
    endtask

    task automatic check_exc(input exc_cause_e got, exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("[ERROR] exc_cause got %08h expected %08h", got, exp);
        end
    endtask

    task automatic check_mem(input int idx, input logic [XLEN-1:0] got, exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("[ERROR] mem[%02h] got %08h expected %08h", idx, got, exp);
        end
    endtask

    // expected rd value, memory word and cause from the instruction rules
    function automatic void lsu_expect(input logic [6:0] opc, input logic [2:0] f3,
            input logic [4:0] f5, input logic [1:0] off, input logic [31:0] old, rs2,
            input logic resv_hit, fault, output logic [31:0] e_reg, e_mem,
            output exc_cause_e e_cause);
        logic [31:0] sh;
        logic [31:0] wd;
        int nb;
        sh = old >> (8 * off);
        wd = rs2 << (8 * off);
        e_mem = old;
        e_reg = old;
        e_cause = (opc == OPC_LOAD || f5 == AMO_LR) ? EXC_LOAD_FAULT : EXC_STORE_FAULT;
        if (fault) return;
        if (opc == OPC_LOAD) begin
            case (f3)
                3'b000:  e_reg = {{24{sh[7]}}, sh[7:0]};
                3'b001:  e_reg = {{16{sh[15]}}, sh[15:0]};
                3'b100:  e_reg = {24'd0, sh[7:0]};
                3'b101:  e_reg = {16'd0, sh[15:0]};
                default: e_reg = old;
            endcase
        end else if (opc == OPC_STORE) begin
            nb = (f3 == 3'b000) ? 1 : (f3 == 3'b001) ? 2 : 4;
            for (int b = 0; b < 4; b++)
                if (b >= off && b < off + nb) e_mem[8*b +: 8] = wd[8*b +: 8];
        end else begin
            case (f5)
                AMO_SWAP: e_mem = rs2;
                AMO_ADD:  e_mem = old + rs2;
                AMO_XOR:  e_mem = old ^ rs2;
                AMO_AND:  e_mem = old & rs2;
                AMO_OR:   e_mem = old | rs2;
                AMO_MIN:  e_mem = ($signed(old) < $signed(rs2)) ? old : rs2;
                AMO_MAX:  e_mem = ($signed(old) > $signed(rs2)) ? old : rs2;
                AMO_MINU: e_mem = (old < rs2) ? old : rs2;
                AMO_MAXU: e_mem = (old > rs2) ? old : rs2;
                AMO_SC: begin
                    e_reg = resv_hit ? 32'd0 : 32'd1;
                    e_mem = resv_hit ? rs2 : old;
                end
                default:  e_mem = old;   // lr
            endcase
        end
    endfunction

//======================================================================
// memory model, stalls and bus stability
//======================================================================

    always @(negedge clk) begin
        mem_rsp_valid = 1'b0;
        if (rsp_cnt > 0) begin
            rsp_cnt--;
            if (rsp_cnt == 0) begin
                mem_rsp_valid = 1'b1;
                mem_rsp_data  = rsp_word;
            end
        end
        if (stalled && (!mem_req_valid || inst_ready || mem_req_addr !== held_addr
                || mem_req_wdata !== held_wdata || mem_req_strb !== held_strb
                || mem_req_op !== held_op)) begin
            errors++;
            $display("request changed or was dropped while stalled at %08h", held_addr);
        end
        mem_req_ready = ($urandom % 100) >= stall_pct;
        if (mem_req_valid && mem_req_ready) begin
            if (mem_req_op == BUS_WRITE) begin
                for (int b = 0; b < 4; b++)
                    if (mem_req_strb[b])
                        mem[mem_req_addr[9:2]][8*b +: 8] = mem_req_wdata[8*b +: 8];
            end else begin
                rsp_word = mem[mem_req_addr[9:2]];
                rsp_cnt  = 1 + $urandom % max_delay;
            end
        end
        stalled    = mem_req_valid && !mem_req_ready;
        held_addr  = mem_req_addr;
        held_wdata = mem_req_wdata;
        held_strb  = mem_req_strb;
        held_op    = mem_req_op;
    end

    // result pulses are stable at the falling edge
    always @(negedge clk) begin
        if (rst_n && reg_wr_en) begin
            seen++;
            if (exp_kind != 1) begin
                errors++;
                $display("unexpected register write to x%0d", reg_idx);
            end
            check_reg("reg_val", reg_val, exp_val);
            check_reg("reg_idx", 32'(reg_idx), 32'(rd_idx));
        end
        if (rst_n && exc_valid) begin
            seen++;
            if (exp_kind != 2) begin
                errors++;
                $display("unexpected exception at pc %08h", exc_pc);
            end
            check_exc(exc_cause, exp_cause);
            check_reg("exc_pc", exc_pc, exp_pc);
            check_reg("exc_inst", exc_inst, exp_inst);
        end
    end

    task automatic run_op(input opcode_e opc, input logic [2:0] f3, input logic [4:0] f5,
            input logic [31:0] addr, rs2, input logic fault);
        logic [31:0] e_mem;
        int idx;
        idx = addr[9:2];
        exp_inst = {f5, 2'b00, 5'd2, 5'd1, f3, 5'd0, opc};
        lsu_expect(opc, f3, f5, addr[1:0], shadow[idx], rs2, resv_v && resv_a == addr[31:2],
                   fault, exp_val, e_mem, exp_cause);
        rd_en    = ($urandom % 8) != 0;          // some ops with no rd write
        exp_kind = fault ? 2 : (opc == OPC_STORE || !rd_en) ? 0 : 1;
        exp_pc   = 32'h1000 + 4 * issued;
        seen     = 0;
        imm      = $urandom % 64;
        rs1_val  = addr - imm;
        rs2_val  = rs2;
        pc       = exp_pc;
        rd_idx   = 1 + $urandom % 31;
        inst     = exp_inst;
        inst_valid = 1'b1;
        @(negedge clk);
        inst_valid = 1'b0;
        while (!inst_ready) @(negedge clk);
        @(negedge clk);
        if (seen != (exp_kind != 0 ? 1 : 0)) begin
            errors++;
            $display("wrong number of results for instruction at pc %08h", exp_pc);
        end
        check_mem(idx, mem[idx], e_mem);
        shadow[idx] = e_mem;
        if (opc == OPC_AMO && f5 == AMO_SC) resv_v = 1'b0;
        if (opc == OPC_AMO && f5 == AMO_LR && !fault) begin
            resv_v = 1'b1;
            resv_a = addr[31:2];
        end
        issued++;
    endtask

    task automatic end_test(input string name);
        $display("test %s: %0d checks, %0d errors", name, checks - t_chk, errors - t_err);
        t_chk = checks;
        t_err = errors;
    endtask

    task automatic set_region(input int idx, input logic [31:0] base, limit,
            input logic r, w);
        cfg_idx = idx[1:0];
        cfg_base = base;
        cfg_limit = limit;
        cfg_r = r;
        cfg_w = w;
        cfg_we = 1'b1;
        @(negedge clk);
        cfg_we = 1'b0;
    endtask

//======================================================================
// stimulus
//======================================================================

    initial begin
        logic [2:0] f3;
        logic [31:0] a;
        logic [4:0] amo_list [9];
        amo_list = '{AMO_SWAP, AMO_ADD, AMO_XOR, AMO_AND, AMO_OR,
                     AMO_MIN, AMO_MAX, AMO_MINU, AMO_MAXU};
        void'($urandom(32'hf8056020));
        rst_n = 1'b0;
        priv_m = 1'b1;
        inst_valid = 1'b0;
        rd_en = 1'b1;
        mem_req_ready = 1'b0;
        mem_rsp_valid = 1'b0;
        mem_rsp_data = '0;
        cfg_we = 1'b0;
        cfg_idx = '0;
        cfg_base = '0;
        cfg_limit = '0;
        cfg_r = 0;
        cfg_w = 0;
        inst = '0;
        pc = '0;
        rs1_val = '0;
        rs2_val = '0;
        imm = '0;
        rd_idx = '0;
        stall_pct = 30;
        max_delay = 4;
        resv_v = 1'b0;
        resv_a = '0;
        for (int i = 0; i < 256; i++) begin
            mem[i]    = 32'h9e3779b9 * (i + 1) ^ {4{i[7:0]}};
            shadow[i] = mem[i];
        end
        repeat (4) @(negedge clk);
        rst_n = 1'b1;
        @(negedge clk);

        for (int i = 0; i < 40; i++) begin
            f3 = 3'($urandom % 3);                       // sb, sh, sw
            a  = 4 * ($urandom % 256);
            a  = a + ((f3 == 0) ? $urandom % 4 : (f3 == 1) ? 2 * ($urandom % 2) : 0);
            run_op(OPC_STORE, f3, 5'd0, a, $urandom, 1'b0);
            f3 = (i % 5 < 3) ? 3'(i % 3) : 3'(i % 5 + 1);  // lb lh lw lbu lhu
            a  = {a[31:2], 2'b00};
            a  = a + ((f3[1:0] == 0) ? $urandom % 4 : (f3[1:0] == 1) ? 2 * ($urandom % 2) : 0);
            run_op(OPC_LOAD, f3, 5'd0, a, 32'd0, 1'b0);
        end
        end_test("loads and stores");

        for (int i = 0; i < 27; i++)
            run_op(OPC_AMO, 3'b010, amo_list[i % 9], 4 * ($urandom % 256), $urandom, 1'b0);
        end_test("amo");

        run_op(OPC_AMO, 3'b010, AMO_LR, 32'h80, 0, 1'b0);
        run_op(OPC_AMO, 3'b010, AMO_SC, 32'h80, 32'hcafe0001, 1'b0);
        run_op(OPC_AMO, 3'b010, AMO_SC, 32'h80, 32'hcafe0002, 1'b0);
        run_op(OPC_AMO, 3'b010, AMO_LR, 32'h84, 0, 1'b0);
        run_op(OPC_AMO, 3'b010, AMO_SC, 32'h88, 32'hcafe0003, 1'b0);
        run_op(OPC_AMO, 3'b010, AMO_SC, 32'h84, 32'hcafe0004, 1'b0);
        end_test("lr/sc");

        set_region(0, 32'h000, 32'h0ff, 1'b1, 1'b0);     // read only
        set_region(1, 32'h100, 32'h1ff, 1'b1, 1'b1);
        priv_m = 1'b0;
        run_op(OPC_LOAD, 3'b010, 5'd0, 32'h300, 0, 1'b1);
        run_op(OPC_STORE, 3'b010, 5'd0, 32'h040, 32'h11223344, 1'b1);
        run_op(OPC_AMO, 3'b010, AMO_ADD, 32'h044, 32'h5, 1'b1);
        run_op(OPC_STORE, 3'b000, 5'd0, 32'h3f1, 32'h55, 1'b1);
        run_op(OPC_LOAD, 3'b100, 5'd0, 32'h041, 0, 1'b0);
        run_op(OPC_AMO, 3'b010, AMO_OR, 32'h140, 32'hf0, 1'b0);
        priv_m = 1'b1;
        end_test("protection");

        stall_pct = 90;
        max_delay = 8;
        for (int i = 0; i < 20; i++)
            run_op((i % 2) ? OPC_LOAD : OPC_STORE, 3'b010, 5'd0, 4 * ($urandom % 256),
                   $urandom, 1'b0);
        end_test("back-pressure");

        $display("%0d checks, %0d errors", checks, errors);
        if (errors == 0) begin
            $display("Simulation finished: PASS");
        end else begin
            $display("Simulation finished: FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* design/lsu_bus_pkg.sv */
`default_nettype none

package lsu_bus_pkg;

    localparam int XLEN       = 32;        // register, address and data
    localparam int STRB_WIDTH = XLEN / 8;

    // access direction seen by the protection check
    typedef enum logic [1:0] {
        ACC_READ  = 2'b01,
        ACC_WRITE = 2'b10
    } access_kind_e;

    typedef enum logic {
        BUS_READ  = 1'b0,
        BUS_WRITE = 1'b1
    } mem_op_e;

    // what writeback should do with a completion
    typedef enum logic [2:0] {
        CPL_LOAD    = 3'd0,
        CPL_AMO_OLD = 3'd1,
        CPL_SC_OK   = 3'd2,
        CPL_SC_FAIL = 3'd3
    } cpl_kind_e;

endpackage

`default_nettype wire

/* design/lsu_isa_pkg.sv */
`default_nettype none

package lsu_isa_pkg;

    localparam int INST_WIDTH = 32;

    // field positions inside the instruction word
    localparam int OPCODE_MSB = 6;
    localparam int FUNCT3_MSB = 14;
    localparam int FUNCT3_LSB = 12;
    localparam int FUNCT5_MSB = 31;
    localparam int FUNCT5_LSB = 27;

    typedef enum logic [6:0] {
        OPC_LOAD  = 7'b0000011,
        OPC_STORE = 7'b0100011,
        OPC_AMO   = 7'b0101111
    } opcode_e;

    typedef enum logic [2:0] {
        F3_LB  = 3'b000,
        F3_LH  = 3'b001,
        F3_LW  = 3'b010,
        F3_LBU = 3'b100,
        F3_LHU = 3'b101
    } funct3_e;

    // store widths reuse the load codes
    localparam funct3_e F3_SB = F3_LB;
    localparam funct3_e F3_SH = F3_LH;
    localparam funct3_e F3_SW = F3_LW;

    typedef enum logic [4:0] {
        AMO_ADD  = 5'b00000,
        AMO_SWAP = 5'b00001,
        AMO_LR   = 5'b00010,
        AMO_SC   = 5'b00011,
        AMO_XOR  = 5'b00100,
        AMO_OR   = 5'b01000,
        AMO_AND  = 5'b01100,
        AMO_MIN  = 5'b10000,
        AMO_MAX  = 5'b10100,
        AMO_MINU = 5'b11000,
        AMO_MAXU = 5'b11100
    } amo_funct5_e;

    typedef enum logic [31:0] {
        EXC_LOAD_FAULT  = 32'd5,
        EXC_STORE_FAULT = 32'd7    // store, sc and amo
    } exc_cause_e;

endpackage

`default_nettype wire

/* design/lsu_top.sv */
`timescale 1ns/100ps
`default_nettype none

module lsu_top #(
    parameter int num_regions = 4
) (
    input  logic                                 clk,
    input  logic                                 rst_n,
    input  logic                                 priv_m,
    // instruction side
    input  logic                                 inst_valid,
    output logic                                 inst_ready,
    input  logic [lsu_isa_pkg::INST_WIDTH-1:0]   inst,
    input  logic [lsu_bus_pkg::XLEN-1:0]         pc,
    input  logic [lsu_bus_pkg::XLEN-1:0]         rs1_val,
    input  logic [lsu_bus_pkg::XLEN-1:0]         rs2_val,
    input  logic [lsu_bus_pkg::XLEN-1:0]         imm,
    input  logic [4:0]                           rd_idx,
    input  logic                                 rd_en,
    // memory side
    output logic                                 mem_req_valid,
    input  logic                                 mem_req_ready,
    output logic [lsu_bus_pkg::XLEN-1:0]         mem_req_addr,
    output logic [lsu_bus_pkg::XLEN-1:0]         mem_req_wdata,
    output logic [lsu_bus_pkg::STRB_WIDTH-1:0]   mem_req_strb,
    output lsu_bus_pkg::mem_op_e                 mem_req_op,
    input  logic                                 mem_rsp_valid,
    input  logic [lsu_bus_pkg::XLEN-1:0]         mem_rsp_data,
    // protection region config
    input  logic                                 cfg_we,
    input  logic [$clog2(num_regions)-1:0]       cfg_idx,
    input  logic [lsu_bus_pkg::XLEN-1:0]         cfg_base,
    input  logic [lsu_bus_pkg::XLEN-1:0]         cfg_limit,
    input  logic                                 cfg_r,
    input  logic                                 cfg_w,
    // register write and exception
    output logic                                 reg_wr_en,
    output logic [4:0]                           reg_idx,
    output logic [lsu_bus_pkg::XLEN-1:0]         reg_val,
    output logic                                 exc_valid,
    output lsu_isa_pkg::exc_cause_e              exc_cause,
    output logic [lsu_bus_pkg::XLEN-1:0]         exc_pc,
    output logic [lsu_isa_pkg::INST_WIDTH-1:0]   exc_inst
);
    import lsu_isa_pkg::*;
    import lsu_bus_pkg::*;

    // sequencer <-> checker
    logic                  chk_valid;
    logic [XLEN-1:0]       chk_addr;
    access_kind_e          chk_kind;
    logic                  chk_grant;
    logic                  fault_valid;
    logic                  fault_store;

    // sequencer -> writeback
    logic                  cpl_valid;
    cpl_kind_e             cpl_kind;
    logic [XLEN-1:0]       cpl_data;
    logic [1:0]            cpl_offset;
    funct3_e               cpl_funct3;
    logic [4:0]            cpl_rd;
    logic                  cpl_rd_en;
    logic [XLEN-1:0]       op_pc;
    logic [INST_WIDTH-1:0] op_inst;

    // port names match the nets above
    pmp_checker #(
        .num_regions (num_regions)
    ) pmp_checker_i (.*);

    mem_sequencer mem_sequencer_i (.*);

    writeback_unit writeback_unit_i (.*);

endmodule

`default_nettype wire

/* design/mem_sequencer.sv */
`timescale 1ns/100ps
`default_nettype none

module mem_sequencer (
    input  logic                                 clk,
    input  logic                                 rst_n,
    input  logic                                 inst_valid,
    output logic                                 inst_ready,
    input  logic [lsu_isa_pkg::INST_WIDTH-1:0]   inst,
    input  logic [lsu_bus_pkg::XLEN-1:0]         pc,
    input  logic [lsu_bus_pkg::XLEN-1:0]         rs1_val,
    input  logic [lsu_bus_pkg::XLEN-1:0]         rs2_val,
    input  logic [lsu_bus_pkg::XLEN-1:0]         imm,
    input  logic [4:0]                           rd_idx,
    input  logic                                 rd_en,
    output logic                                 mem_req_valid,
    input  logic                                 mem_req_ready,
    output logic [lsu_bus_pkg::XLEN-1:0]         mem_req_addr,
    output logic [lsu_bus_pkg::XLEN-1:0]         mem_req_wdata,
    output logic [lsu_bus_pkg::STRB_WIDTH-1:0]   mem_req_strb,
    output lsu_bus_pkg::mem_op_e                 mem_req_op,
    input  logic                                 mem_rsp_valid,
    input  logic [lsu_bus_pkg::XLEN-1:0]         mem_rsp_data,
    output logic                                 chk_valid,
    output logic [lsu_bus_pkg::XLEN-1:0]         chk_addr,
    output lsu_bus_pkg::access_kind_e            chk_kind,
    input  logic                                 chk_grant,
    output logic                                 cpl_valid,
    output lsu_bus_pkg::cpl_kind_e               cpl_kind,
    output logic [lsu_bus_pkg::XLEN-1:0]         cpl_data,
    output logic [1:0]                           cpl_offset,
    output lsu_isa_pkg::funct3_e                 cpl_funct3,
    output logic [4:0]                           cpl_rd,
    output logic                                 cpl_rd_en,
    output logic [lsu_bus_pkg::XLEN-1:0]         op_pc,
    output logic [lsu_isa_pkg::INST_WIDTH-1:0]   op_inst
);
    import lsu_isa_pkg::*;
    import lsu_bus_pkg::*;

    typedef enum logic [2:0] {
        ST_IDLE, ST_CHECK, ST_REQ, ST_WAIT_RSP, ST_AMO_WR, ST_SC_WR
    } state_e;

    state_e                state;
    state_e                state_nxt;
    logic [INST_WIDTH-1:0] inst_q;
    logic [XLEN-1:0]       pc_q;
    logic [XLEN-1:0]       addr_q;
    logic [XLEN-1:0]       rs2_q;
    logic [XLEN-1:0]       old_q;
    logic [XLEN-1:0]       amo_result;
    logic [XLEN-1:2]       resv_addr;
    logic                  resv_valid;
    logic [4:0]            rd_q;
    logic                  rd_en_q;
    logic [4:0]            funct5;
    logic [2:0]            funct3;
    logic                  is_load;
    logic                  is_store;
    logic                  is_amo_op;
    logic                  is_lr;
    logic                  is_sc;
    logic                  sc_match;
    logic                  req_hs;
    logic [STRB_WIDTH-1:0] size_strb;

//======================================================================
// operation capture and decode
//======================================================================

    always_ff @(posedge clk) begin
        if (inst_valid && inst_ready) begin
            inst_q  <= inst;
            pc_q    <= pc;
            addr_q  <= rs1_val + imm;
            rs2_q   <= rs2_val;
            rd_q    <= rd_idx;
            rd_en_q <= rd_en;
        end
    end

    always_ff @(posedge clk) begin
        if (state == ST_WAIT_RSP && mem_rsp_valid) begin
            old_q <= mem_rsp_data;             // amo operand and old value
        end
    end

    assign funct3    = inst_q[FUNCT3_MSB:FUNCT3_LSB];
    assign funct5    = inst_q[FUNCT5_MSB:FUNCT5_LSB];
    assign is_load   = (inst_q[OPCODE_MSB:0] == OPC_LOAD);
    assign is_store  = (inst_q[OPCODE_MSB:0] == OPC_STORE);
    assign is_amo_op = (inst_q[OPCODE_MSB:0] == OPC_AMO);
    assign is_lr     = is_amo_op && (funct5 == AMO_LR);
    assign is_sc     = is_amo_op && (funct5 == AMO_SC);

//======================================================================
// lr/sc reservation
//======================================================================

    assign sc_match = resv_valid && (resv_addr == addr_q[XLEN-1:2]);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            resv_valid <= 1'b0;
        end else if (state == ST_CHECK && is_sc) begin
            resv_valid <= 1'b0;                // any sc drops it
        end else if (state == ST_CHECK && is_lr && chk_grant) begin
            resv_valid <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (state == ST_CHECK && is_lr && chk_grant) begin
            resv_addr <= addr_q[XLEN-1:2];
        end
    end

//======================================================================
// sequencing
//======================================================================

    assign req_hs = mem_req_valid && mem_req_ready;

    always_comb begin
        state_nxt = state;
        case (state)
            ST_IDLE: begin
                if (inst_valid) state_nxt = ST_CHECK;
            end
            ST_CHECK: begin
                if (!chk_grant || (is_sc && !sc_match)) state_nxt = ST_IDLE;
                else if (is_sc)   state_nxt = req_hs ? ST_IDLE : ST_SC_WR;
                else if (!req_hs) state_nxt = ST_REQ;
                else              state_nxt = is_store ? ST_IDLE : ST_WAIT_RSP;
            end
            ST_REQ: begin
                if (req_hs) state_nxt = is_store ? ST_IDLE : ST_WAIT_RSP;
            end
            ST_WAIT_RSP: begin
                if (mem_rsp_valid) state_nxt = (is_lr || !is_amo_op) ? ST_IDLE : ST_AMO_WR;
            end
            ST_AMO_WR, ST_SC_WR: begin
                if (req_hs) state_nxt = ST_IDLE;
            end
            default: state_nxt = ST_IDLE;
        endcase
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state <= ST_IDLE;
        end else begin
            state <= state_nxt;
        end
    end

    assign inst_ready = (state == ST_IDLE);   // one op in flight
    assign chk_valid  = (state == ST_CHECK);
    assign chk_addr   = addr_q;
    assign chk_kind   = (is_load || is_lr) ? ACC_READ : ACC_WRITE;

//======================================================================
// memory request
//======================================================================

    // first request goes out with the check, refused ones never leave
    assign mem_req_valid = (state == ST_CHECK && chk_grant && !(is_sc && !sc_match))
                        || state == ST_REQ || state == ST_AMO_WR || state == ST_SC_WR;
    assign mem_req_addr  = {addr_q[XLEN-1:2], 2'b00};
    assign mem_req_op    = (is_store || is_sc || state == ST_AMO_WR) ? BUS_WRITE : BUS_READ;

    always_comb begin
        case (funct3)
            F3_SB, F3_LBU: size_strb = STRB_WIDTH'(4'b0001);
            F3_SH, F3_LHU: size_strb = STRB_WIDTH'(4'b0011);
            F3_SW:         size_strb = '1;
            default:       size_strb = '0;
        endcase
    end

    assign mem_req_strb  = is_amo_op ? '1 : size_strb << addr_q[1:0];
    assign mem_req_wdata = (state == ST_AMO_WR) ? amo_result
                         : is_sc ? rs2_q
                         : rs2_q << {addr_q[1:0], 3'b000};

    always_comb begin
        case (funct5)
            AMO_SWAP: amo_result = rs2_q;
            AMO_ADD:  amo_result = old_q + rs2_q;
            AMO_XOR:  amo_result = old_q ^ rs2_q;
            AMO_AND:  amo_result = old_q & rs2_q;
            AMO_OR:   amo_result = old_q | rs2_q;
            AMO_MIN:  amo_result = ($signed(rs2_q) < $signed(old_q)) ? rs2_q : old_q;
            AMO_MAX:  amo_result = ($signed(rs2_q) < $signed(old_q)) ? old_q : rs2_q;
            AMO_MINU: amo_result = (rs2_q < old_q) ? rs2_q : old_q;
            AMO_MAXU: amo_result = (rs2_q < old_q) ? old_q : rs2_q;
            default:  amo_result = rs2_q;
        endcase
    end

//======================================================================
// completion to writeback
//======================================================================

    assign cpl_valid = (state == ST_CHECK && chk_grant && is_sc && !sc_match)
                    || (state == ST_WAIT_RSP && mem_rsp_valid && (is_lr || !is_amo_op))
                    || ((state == ST_AMO_WR || is_sc) && req_hs);

    always_comb begin
        if (is_sc) begin
            cpl_kind = (sc_match || state == ST_SC_WR) ? CPL_SC_OK : CPL_SC_FAIL;
        end else if (is_amo_op) begin
            cpl_kind = CPL_AMO_OLD;            // lr shares the old word path
        end else begin
            cpl_kind = CPL_LOAD;
        end
    end

    assign cpl_data   = (state == ST_AMO_WR) ? old_q : mem_rsp_data;
    assign cpl_offset = addr_q[1:0];
    assign cpl_funct3 = funct3_e'(funct3);
    assign cpl_rd     = rd_q;
    assign cpl_rd_en  = rd_en_q;
    assign op_pc      = pc_q;
    assign op_inst    = inst_q;

endmodule

`default_nettype wire

/* design/pmp_checker.sv */
`timescale 1ns/100ps
`default_nettype none

module pmp_checker #(
    parameter int num_regions = 4
) (
    input  logic                             clk,
    input  logic                             rst_n,
    input  logic                             priv_m,
    input  logic                             cfg_we,
    input  logic [$clog2(num_regions)-1:0]   cfg_idx,
    input  logic [lsu_bus_pkg::XLEN-1:0]     cfg_base,
    input  logic [lsu_bus_pkg::XLEN-1:0]     cfg_limit,
    input  logic                             cfg_r,
    input  logic                             cfg_w,
    input  logic                             chk_valid,
    input  logic [lsu_bus_pkg::XLEN-1:0]     chk_addr,
    input  lsu_bus_pkg::access_kind_e        chk_kind,
    output logic                             chk_grant,
    output logic                             fault_valid,
    output logic                             fault_store
);
    import lsu_bus_pkg::*;

    logic [XLEN-1:0]        region_base  [num_regions];
    logic [XLEN-1:0]        region_limit [num_regions];
    logic [num_regions-1:0] region_r;
    logic [num_regions-1:0] region_w;
    logic [num_regions-1:0] region_en;
    logic [num_regions-1:0] region_hit;
    logic                   need_write;

//======================================================================
// region configuration
//======================================================================

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            region_en <= '0;                    // all regions off
        end else if (cfg_we) begin
            region_en[cfg_idx] <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (cfg_we) begin
            region_base[cfg_idx]  <= cfg_base;
            region_limit[cfg_idx] <= cfg_limit; // inclusive upper bound
            region_r[cfg_idx]     <= cfg_r;
            region_w[cfg_idx]     <= cfg_w;
        end
    end

//======================================================================
// permission check
//======================================================================

    assign need_write = (chk_kind == ACC_WRITE);

    // every region compared in parallel
    always_comb begin
        for (int i = 0; i < num_regions; i++) begin
            region_hit[i] = region_en[i]
                && (chk_addr >= region_base[i]) && (chk_addr <= region_limit[i])
                && (((chk_kind == ACC_READ) && region_r[i])
                    || ((chk_kind == ACC_WRITE) && region_w[i]));
        end
    end

    assign chk_grant = priv_m || (|region_hit);   // machine mode bypasses regions

    // one-cycle fault report, a cycle after the refused check
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            fault_valid <= 1'b0;
        end else begin
            fault_valid <= chk_valid && !chk_grant;
        end
    end

    always_ff @(posedge clk) begin
        if (chk_valid) begin
            fault_store <= need_write;
        end
    end

endmodule

`default_nettype wire

/* design/writeback_unit.sv */
`timescale 1ns/100ps
`default_nettype none

module writeback_unit (
    input  logic                                 clk,
    input  logic                                 rst_n,
    input  logic                                 cpl_valid,
    input  lsu_bus_pkg::cpl_kind_e               cpl_kind,
    input  logic [lsu_bus_pkg::XLEN-1:0]         cpl_data,
    input  logic [1:0]                           cpl_offset,
    input  lsu_isa_pkg::funct3_e                 cpl_funct3,
    input  logic [4:0]                           cpl_rd,
    input  logic                                 cpl_rd_en,
    input  logic [lsu_bus_pkg::XLEN-1:0]         op_pc,
    input  logic [lsu_isa_pkg::INST_WIDTH-1:0]   op_inst,
    input  logic                                 fault_valid,
    input  logic                                 fault_store,
    output logic                                 reg_wr_en,
    output logic [4:0]                           reg_idx,
    output logic [lsu_bus_pkg::XLEN-1:0]         reg_val,
    output logic                                 exc_valid,
    output lsu_isa_pkg::exc_cause_e              exc_cause,
    output logic [lsu_bus_pkg::XLEN-1:0]         exc_pc,
    output logic [lsu_isa_pkg::INST_WIDTH-1:0]   exc_inst
);
    import lsu_isa_pkg::*;
    import lsu_bus_pkg::*;

    logic [XLEN-1:0] shifted;
    logic [XLEN-1:0] result;

    assign shifted = cpl_data >> {cpl_offset, 3'b000};   // addressed byte to bit 0

    always_comb begin
        case (cpl_kind)
            CPL_LOAD: begin
                case (cpl_funct3)
                    F3_LB:   result = {{(XLEN-8){shifted[7]}}, shifted[7:0]};
                    F3_LBU:  result = {{(XLEN-8){1'b0}}, shifted[7:0]};
                    F3_LH:   result = {{(XLEN-16){shifted[15]}}, shifted[15:0]};
                    F3_LHU:  result = {{(XLEN-16){1'b0}}, shifted[15:0]};
                    default: result = shifted;
                endcase
            end
            CPL_AMO_OLD: result = cpl_data;
            CPL_SC_OK:   result = '0;
            CPL_SC_FAIL: result = XLEN'(1);
            default:     result = cpl_data;
        endcase
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            reg_wr_en <= 1'b0;
        end else begin
            reg_wr_en <= cpl_valid && cpl_rd_en;
        end
    end

    always_ff @(posedge clk) begin
        if (cpl_valid) begin
            reg_idx <= cpl_rd;
            reg_val <= result;
        end
    end

    // fault pulse is already registered, op_pc/op_inst still hold the op
    assign exc_valid = fault_valid;
    assign exc_cause = fault_store ? EXC_STORE_FAULT : EXC_LOAD_FAULT;
    assign exc_pc    = op_pc;
    assign exc_inst  = op_inst;

endmodule

`default_nettype wire

/* run_sim.sh */
#!/bin/sh
# build and run the lsu testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing -Wno-fatal --top-module lsu_tb -f vlog.f -o lsu_sim \
    && ./obj_dir/lsu_sim | tee /dev/stderr | grep -q "Simulation finished: PASS" \
    && echo "run passed" \
    || { echo "run failed"; exit 1; }

/* vlog.f */
design/lsu_isa_pkg.sv
design/lsu_bus_pkg.sv
design/pmp_checker.sv
design/mem_sequencer.sv
design/writeback_unit.sv
design/lsu_top.sv
bench/lsu_tb.sv
